// File: common/rv_core_pkg.sv
package rv_core_pkg;

    // ========================================================================
    // Basic data types
    // ========================================================================

    // Data word and instruction address.
    typedef logic [31:0] word_t;

    // Architectural register index.
    typedef logic [4:0] reg_idx_t;

    // Size of the integer register file.
    localparam int unsigned NUM_REGS = 32;

    // ========================================================================
    // Decoded operations
    // ========================================================================

    // One code per operation class the execute block understands.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        // Passes operand B through, used by LUI.
        ALU_PASS_B,
        ALU_BR_EQ,
        ALU_BR_NE,
        ALU_JUMP,
        ALU_ILLEGAL
    } alu_op_t;

    // ========================================================================
    // Encoding constants
    // ========================================================================

    // Major opcodes, bits [6:0] of the instruction.
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Minor opcodes, bits [14:12].
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // Bits [31:25] of register-register forms.
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

// File: common/dec_exec_if.sv
interface dec_exec_if import rv_core_pkg::*; ();

    // Single-cycle strobe marking a new decoded instruction.
    logic     issue;

    // Operation class.
    alu_op_t  op;

    // Address of the decoded instruction.
    word_t    pc;

    // Register operands as read at decode time.
    word_t    rs1_val;
    word_t    rs2_val;

    // Sign-extended or shifted immediate.
    word_t    imm;

    // Selects imm instead of rs2_val as operand B.
    logic     use_imm;

    // Destination register and its write enable.
    reg_idx_t rd;
    logic     wr_en;

    // Decode side.
    modport src (
        output issue, op, pc, rs1_val, rs2_val, imm, use_imm, rd, wr_en
    );

    // Execute side.
    modport dst (
        input issue, op, pc, rs1_val, rs2_val, imm, use_imm, rd, wr_en
    );

endinterface

// File: hdl/inst_fetch.sv
module inst_fetch import rv_core_pkg::*; #(
    parameter word_t BOOT_ADDR = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  next_en,
    input  logic  jmp_en,
    input  word_t jmp_pc,
    input  word_t inst_data,
    input  logic  inst_mem_ready,
    output logic  inst_req,
    output word_t inst_addr,
    output word_t cur_inst_addr,
    output word_t inst_code,
    output logic  inst_ready
);

    // Address of the word to fetch next.
    word_t next_inst_addr;
    // High while a request to memory is outstanding.
    logic  waiting;
    // Low only in the first cycle after reset.
    logic  started;

    assign inst_req  = waiting;
    assign inst_addr = next_inst_addr;

    // ========================================================================
    // Request and redirect control
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst) begin
            next_inst_addr <= BOOT_ADDR;
            waiting        <= 1'b0;
            started        <= 1'b0;
            inst_ready     <= 1'b0;
        end else begin
            inst_ready <= 1'b0;
            // First fetch after reset release.
            if (!started) begin
                started <= 1'b1;
                waiting <= 1'b1;
            end
            // Memory answered.
            if (waiting && inst_mem_ready) begin
                waiting    <= 1'b0;
                inst_ready <= 1'b1;
            end
            // Retirement starts the next fetch.
            if (next_en) begin
                waiting        <= 1'b1;
                next_inst_addr <= jmp_en ? jmp_pc : next_inst_addr + 32'd4;
            end
        end
    end

    // Captured word and its address, held until the next capture.
    always_ff @(posedge clk) begin
        if (waiting && inst_mem_ready) begin
            inst_code     <= inst_data;
            cur_inst_addr <= next_inst_addr;
        end
    end

    // Memory answers only an outstanding request.
    a_ready_needs_wait: assert property (
        @(posedge clk) disable iff (!rst)
        inst_mem_ready |-> waiting
    );

endmodule

// File: hdl/inst_decode.sv
module inst_decode import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  word_t    inst_code,
    input  word_t    cur_inst_addr,
    input  logic     inst_ready,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    input  word_t    rs1_val,
    input  word_t    rs2_val,
    dec_exec_if.src  dec
);

    // ========================================================================
    // Field extraction
    // ========================================================================

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd_idx;

    assign opcode  = inst_code[6:0];
    assign rd_idx  = inst_code[11:7];
    assign funct3  = inst_code[14:12];
    assign rs1_idx = inst_code[19:15];
    assign rs2_idx = inst_code[24:20];
    assign funct7  = inst_code[31:25];

    // Immediates for each format.
    word_t imm_i;
    word_t imm_u;
    word_t imm_j;
    word_t imm_b;

    assign imm_i = {{20{inst_code[31]}}, inst_code[31:20]};
    assign imm_u = {inst_code[31:12], 12'b0};
    assign imm_j = {{12{inst_code[31]}}, inst_code[19:12], inst_code[20],
                    inst_code[30:21], 1'b0};
    assign imm_b = {{20{inst_code[31]}}, inst_code[7], inst_code[30:25],
                    inst_code[11:8], 1'b0};

    // ========================================================================
    // Operation classification
    // ========================================================================

    alu_op_t op_d;
    word_t   imm_d;
    logic    use_imm_d;
    logic    writes_d;

    always_comb begin
        op_d      = ALU_ILLEGAL;
        imm_d     = imm_i;
        use_imm_d = 1'b0;
        writes_d  = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                use_imm_d = 1'b1;
                writes_d  = 1'b1;
                case (funct3)
                    F3_ADD:  op_d = ALU_ADD;
                    F3_XOR:  op_d = ALU_XOR;
                    F3_OR:   op_d = ALU_OR;
                    F3_AND:  op_d = ALU_AND;
                    default: op_d = ALU_ILLEGAL;
                endcase
            end
            OPC_OP: begin
                writes_d = 1'b1;
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD:  op_d = ALU_ADD;
                        F3_XOR:  op_d = ALU_XOR;
                        F3_OR:   op_d = ALU_OR;
                        F3_AND:  op_d = ALU_AND;
                        default: op_d = ALU_ILLEGAL;
                    endcase
                end else if (funct7 == F7_ALT && funct3 == F3_ADD) begin
                    op_d = ALU_SUB;
                end
            end
            OPC_LUI: begin
                op_d      = ALU_PASS_B;
                imm_d     = imm_u;
                use_imm_d = 1'b1;
                writes_d  = 1'b1;
            end
            OPC_JAL: begin
                op_d     = ALU_JUMP;
                imm_d    = imm_j;
                writes_d = 1'b1;
            end
            OPC_BRANCH: begin
                imm_d = imm_b;
                if (funct3 == F3_BEQ) begin
                    op_d = ALU_BR_EQ;
                end else if (funct3 == F3_BNE) begin
                    op_d = ALU_BR_NE;
                end
            end
            default: op_d = ALU_ILLEGAL;
        endcase
        // Illegal encodings and x0 targets write nothing.
        if (op_d == ALU_ILLEGAL || rd_idx == '0) begin
            writes_d = 1'b0;
        end
    end

    // ========================================================================
    // Issue register
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst) begin
            dec.issue <= 1'b0;
        end else begin
            dec.issue <= inst_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_ready) begin
            dec.op      <= op_d;
            dec.pc      <= cur_inst_addr;
            dec.rs1_val <= rs1_val;
            dec.rs2_val <= rs2_val;
            dec.imm     <= imm_d;
            dec.use_imm <= use_imm_d;
            dec.rd      <= rd_idx;
            dec.wr_en   <= writes_d;
        end
    end

    // The fetch strobe lasts one cycle, so each word issues once.
    a_ready_single: assert property (
        @(posedge clk) disable iff (!rst)
        inst_ready |=> !inst_ready
    );

endmodule

// File: hdl/exec_alu.sv
module exec_alu import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    dec_exec_if.dst  dec,
    output logic     done,
    output word_t    result,
    output reg_idx_t rd,
    output logic     wr_en,
    output word_t    pc,
    output logic     illegal,
    output logic     jmp_en,
    output word_t    jmp_pc
);

    // ========================================================================
    // Combinational datapath
    // ========================================================================

    word_t opnd_b;
    word_t alu_res;
    word_t seq_pc;
    word_t tgt_pc;
    logic  taken;
    logic  equal;

    assign opnd_b = dec.use_imm ? dec.imm : dec.rs2_val;
    assign seq_pc = dec.pc + 32'd4;
    // JAL and branch targets are both pc-relative.
    assign tgt_pc = dec.pc + dec.imm;
    assign equal  = (dec.rs1_val == dec.rs2_val);

    always_comb begin
        alu_res = '0;
        taken   = 1'b0;
        case (dec.op)
            ALU_ADD:    alu_res = dec.rs1_val + opnd_b;
            ALU_SUB:    alu_res = dec.rs1_val - opnd_b;
            ALU_AND:    alu_res = dec.rs1_val & opnd_b;
            ALU_OR:     alu_res = dec.rs1_val | opnd_b;
            ALU_XOR:    alu_res = dec.rs1_val ^ opnd_b;
            ALU_PASS_B: alu_res = opnd_b;
            ALU_BR_EQ:  taken   = equal;
            ALU_BR_NE:  taken   = !equal;
            // Link value goes to rd.
            ALU_JUMP: begin
                alu_res = seq_pc;
                taken   = 1'b1;
            end
            default:    alu_res = '0;
        endcase
    end

    // ========================================================================
    // Output register
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst) begin
            done <= 1'b0;
        end else begin
            done <= dec.issue;
        end
    end

    always_ff @(posedge clk) begin
        if (dec.issue) begin
            result  <= alu_res;
            rd      <= dec.rd;
            wr_en   <= dec.wr_en;
            pc      <= dec.pc;
            illegal <= (dec.op == ALU_ILLEGAL);
            jmp_en  <= taken;
            jmp_pc  <= tgt_pc;
        end
    end

endmodule

// File: hdl/result_write.sv
module result_write import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     done,
    input  logic     wr_en,
    input  logic     illegal,
    input  logic     jmp_en,
    input  word_t    result,
    input  word_t    pc,
    input  word_t    jmp_pc,
    input  reg_idx_t rd,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output word_t    rs1_val,
    output word_t    rs2_val,
    output logic     next_en,
    output logic     fetch_jmp_en,
    output word_t    fetch_jmp_pc,
    output logic     retire,
    output logic     retire_illegal,
    output logic     wb_en,
    output word_t    retire_pc,
    output word_t    wb_data,
    output reg_idx_t wb_rd
);

    // ========================================================================
    // Register file
    // ========================================================================

    word_t regs [NUM_REGS];

    // x0 is hardwired to zero.
    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (done && wr_en && rd != '0) begin
            regs[rd] <= result;
        end
    end

    // ========================================================================
    // Retire and fetch control
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst) begin
            retire         <= 1'b0;
            next_en        <= 1'b0;
            wb_en          <= 1'b0;
            fetch_jmp_en   <= 1'b0;
            retire_illegal <= 1'b0;
        end else begin
            retire         <= done;
            next_en        <= done;
            wb_en          <= done && wr_en;
            fetch_jmp_en   <= done && jmp_en;
            retire_illegal <= done && illegal;
        end
    end

    // Observation and redirect payload.
    always_ff @(posedge clk) begin
        if (done) begin
            retire_pc    <= pc;
            wb_rd        <= rd;
            wb_data      <= result;
            fetch_jmp_pc <= jmp_pc;
        end
    end

    // Register x0 is never reported as a write target.
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst)
        wb_en |-> (wb_rd != '0)
    );

endmodule

// File: hdl/rv_core_top.sv
module rv_core_top import rv_core_pkg::*; #(
    parameter word_t BOOT_ADDR = 32'h0000_0000
) (
    input  logic     clk,
    input  logic     rst,
    output logic     inst_req,
    output word_t    inst_addr,
    input  word_t    inst_data,
    input  logic     inst_mem_ready,
    output logic     retire,
    output word_t    retire_pc,
    output logic     retire_illegal,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    // Fetch to decode.
    word_t    inst_code;
    word_t    cur_inst_addr;
    logic     inst_ready;

    // Register file read ports.
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_val;
    word_t    rs2_val;

    // Execute to result.
    logic     ex_done;
    word_t    ex_result;
    reg_idx_t ex_rd;
    logic     ex_wr_en;
    word_t    ex_pc;
    logic     ex_illegal;
    logic     ex_jmp_en;
    word_t    ex_jmp_pc;

    // Result back to fetch.
    logic     next_en;
    logic     jmp_en;
    word_t    jmp_pc;

    dec_exec_if dec_exec ();

    // ========================================================================
    // Stages
    // ========================================================================

    inst_fetch #(
        .BOOT_ADDR (BOOT_ADDR)
    ) u_fetch (
        .clk            (clk),
        .rst            (rst),
        .next_en        (next_en),
        .jmp_en         (jmp_en),
        .jmp_pc         (jmp_pc),
        .inst_data      (inst_data),
        .inst_mem_ready (inst_mem_ready),
        .inst_req       (inst_req),
        .inst_addr      (inst_addr),
        .cur_inst_addr  (cur_inst_addr),
        .inst_code      (inst_code),
        .inst_ready     (inst_ready)
    );

    inst_decode u_decode (
        .clk           (clk),
        .rst           (rst),
        .inst_code     (inst_code),
        .cur_inst_addr (cur_inst_addr),
        .inst_ready    (inst_ready),
        .rs1_idx       (rs1_idx),
        .rs2_idx       (rs2_idx),
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .dec           (dec_exec.src)
    );

    exec_alu u_exec (
        .clk     (clk),
        .rst     (rst),
        .dec     (dec_exec.dst),
        .done    (ex_done),
        .result  (ex_result),
        .rd      (ex_rd),
        .wr_en   (ex_wr_en),
        .pc      (ex_pc),
        .illegal (ex_illegal),
        .jmp_en  (ex_jmp_en),
        .jmp_pc  (ex_jmp_pc)
    );

    result_write u_result (
        .clk            (clk),
        .rst            (rst),
        .done           (ex_done),
        .wr_en          (ex_wr_en),
        .illegal        (ex_illegal),
        .jmp_en         (ex_jmp_en),
        .result         (ex_result),
        .pc             (ex_pc),
        .jmp_pc         (ex_jmp_pc),
        .rd             (ex_rd),
        .rs1_idx        (rs1_idx),
        .rs2_idx        (rs2_idx),
        .rs1_val        (rs1_val),
        .rs2_val        (rs2_val),
        .next_en        (next_en),
        .fetch_jmp_en   (jmp_en),
        .fetch_jmp_pc   (jmp_pc),
        .retire         (retire),
        .retire_illegal (retire_illegal),
        .wb_en          (wb_en),
        .retire_pc      (retire_pc),
        .wb_data        (wb_data),
        .wb_rd          (wb_rd)
    );

endmodule

// File: dv/tb_rv_core.sv
module tb_rv_core import rv_core_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    // ========================================================================
    // Constants
    // ========================================================================

    localparam word_t BOOT_ADDR = 32'h0000_0100;

    // Program memory size in words, starting at BOOT_ADDR.
    localparam int MEM_WORDS = 64;

    // Words outside a program. Bits [1:0] stay 00, so they decode as illegal.
    localparam word_t FILL_MASK = 32'h5a5a_5a00;

    localparam logic [31:0] LFSR_SEED = 32'hc79e_aefe;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // Instructions retired per test. The reset test only fetches.
    localparam int RESET_INSTS   = 1;
    localparam int ALU_INSTS     = 12;
    localparam int X0_INSTS      = 3;
    localparam int BRANCH_INSTS  = 6;
    localparam int ILLEGAL_INSTS = 3;
    localparam int TOTAL_INSTS   = RESET_INSTS + 2 * ALU_INSTS + X0_INSTS
                                   + BRANCH_INSTS + ILLEGAL_INSTS;

    // Worst case 4 core plus 4 memory cycles per instruction.
    localparam int TIMEOUT_CYCLES = TOTAL_INSTS * 8 + 100;

    // ========================================================================
    // DUT and clock
    // ========================================================================

    logic     clk = 1'b0;
    logic     rst;
    logic     inst_req;
    word_t    inst_addr;
    word_t    inst_data = '0;
    logic     inst_mem_ready = 1'b0;
    logic     retire;
    word_t    retire_pc;
    logic     retire_illegal;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    rv_core_top #(
        .BOOT_ADDR (BOOT_ADDR)
    ) uut (
        .clk            (clk),
        .rst            (rst),
        .inst_req       (inst_req),
        .inst_addr      (inst_addr),
        .inst_data      (inst_data),
        .inst_mem_ready (inst_mem_ready),
        .retire         (retire),
        .retire_pc      (retire_pc),
        .retire_illegal (retire_illegal),
        .wb_en          (wb_en),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

    always #4 clk = ~clk;

    // Bookkeeping.
    int cycle_count = 0;
    int ready_edge  = 0;
    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;

    // ========================================================================
    // Instruction memory model
    // ========================================================================

    word_t       imem [MEM_WORDS];
    logic [31:0] lfsr_state   = LFSR_SEED;
    logic        rand_latency = 1'b0;
    logic        mem_busy     = 1'b0;
    int          idle_left    = 0;

    // Galois form, one step per random bit.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // Two bits give 0 to 3 idle cycles.
    task automatic draw_latency(output int cycles);
        logic [1:0] bits;
        bits[0]    = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        bits[1]    = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        cycles     = int'(bits);
    endtask

    function automatic word_t read_word(input word_t addr);
        word_t idx;
        idx = (addr - BOOT_ADDR) >> 2;
        if (idx < MEM_WORDS) begin
            return imem[idx];
        end
        return addr ^ FILL_MASK;
    endfunction

    task automatic clear_mem();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = (BOOT_ADDR + 4 * i) ^ FILL_MASK;
        end
    endtask

    task automatic store(input word_t addr, input word_t inst);
        imem[(addr - BOOT_ADDR) >> 2] = inst;
    endtask

    // Answers a request after the idle cycles, with a one-cycle ready.
    always @(negedge clk) begin
        if (!rst) begin
            inst_mem_ready = 1'b0;
            mem_busy       = 1'b0;
            idle_left      = 0;
        end else if (inst_mem_ready) begin
            inst_mem_ready = 1'b0;
        end else if (inst_req) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                if (rand_latency) begin
                    draw_latency(idle_left);
                end else begin
                    idle_left = 0;
                end
            end
            if (idle_left == 0) begin
                inst_data      = read_word(inst_addr);
                inst_mem_ready = 1'b1;
                // Edge at which the DUT samples the answer.
                ready_edge     = cycle_count + 1;
                mem_busy       = 1'b0;
            end else begin
                idle_left--;
            end
        end
    end

    // ========================================================================
    // Instruction encoders
    // ========================================================================

    function automatic word_t enc_i(input logic [2:0] f3, input reg_idx_t rd,
                                    input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1,
                                    input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_u(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t enc_j(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t enc_b(input logic [2:0] f3, input reg_idx_t rs1,
                                    input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    // ========================================================================
    // Compare tasks
    // ========================================================================

    task automatic check_word(input string name, input word_t exp, input word_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[FAIL] %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp,
                             input reg_idx_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[FAIL] %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[FAIL] %s: expected %h, got %h", name, exp, act);
        end
    endtask

    // ========================================================================
    // Sequencing helpers
    // ========================================================================

    // Outputs are sampled on the falling edge, away from DUT updates.
    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_bit("inst_req", 1'b0, inst_req);
            check_bit("retire", 1'b0, retire);
        end
        rst = 1'b1;
    endtask

    task automatic wait_retire();
        @(negedge clk);
        while (retire !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic expect_retire(input word_t pc, input logic illegal, input logic wen,
                                 input reg_idx_t rd, input word_t data);
        int gap;
        wait_retire();
        check_word("retire_pc", pc, retire_pc);
        check_bit("retire_illegal", illegal, retire_illegal);
        check_bit("wb_en", wen, wb_en);
        if (wen) begin
            check_idx("wb_rd", rd, wb_rd);
            check_word("wb_data", data, wb_data);
        end
        // Ready edge, then inst_ready, issue, done and retire.
        gap = cycle_count - ready_edge;
        check_count++;
        if (gap != 3) begin
            error_count++;
            $display("Retire at pc %h came %0d cycles after memory ready, not 3",
                     pc, gap);
        end
    endtask

    // Fetch address one cycle after retire.
    task automatic check_next_addr(input word_t exp);
        @(negedge clk);
        check_word("inst_addr", exp, inst_addr);
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s %0d errors", name, error_count - errs_before);
        end
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic test_reset();
        int errs;
        errs         = error_count;
        rand_latency = 1'b0;
        clear_mem();
        apply_reset();
        @(negedge clk);
        while (inst_req !== 1'b1) begin
            @(negedge clk);
        end
        check_word("inst_addr", BOOT_ADDR, inst_addr);
        end_test("reset", errs);
    endtask

    // Shared by the fixed and the random latency runs.
    task automatic run_alu_program(input string name, input logic random);
        int errs;
        errs         = error_count;
        rand_latency = random;
        clear_mem();
        store(32'h0000_0100, enc_i(F3_ADD, 5'd1, 5'd0, 12'h123));
        store(32'h0000_0104, enc_i(F3_ADD, 5'd2, 5'd0, 12'hffb));
        store(32'h0000_0108, enc_r(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2));
        store(32'h0000_010c, enc_r(F7_ALT, F3_ADD, 5'd4, 5'd1, 5'd2));
        store(32'h0000_0110, enc_r(F7_BASE, F3_AND, 5'd5, 5'd1, 5'd2));
        store(32'h0000_0114, enc_r(F7_BASE, F3_OR, 5'd6, 5'd1, 5'd2));
        store(32'h0000_0118, enc_r(F7_BASE, F3_XOR, 5'd7, 5'd1, 5'd2));
        store(32'h0000_011c, enc_i(F3_AND, 5'd8, 5'd7, 12'h0f0));
        store(32'h0000_0120, enc_i(F3_OR, 5'd9, 5'd8, 12'h70f));
        store(32'h0000_0124, enc_i(F3_XOR, 5'd10, 5'd9, 12'hfff));
        store(32'h0000_0128, enc_u(5'd11, 20'habcde));
        store(32'h0000_012c, enc_i(F3_ADD, 5'd12, 5'd11, 12'h7ff));
        apply_reset();
        expect_retire(32'h0000_0100, 1'b0, 1'b1, 5'd1, 32'h0000_0123);
        expect_retire(32'h0000_0104, 1'b0, 1'b1, 5'd2, 32'hffff_fffb);
        expect_retire(32'h0000_0108, 1'b0, 1'b1, 5'd3, 32'h0000_011e);
        expect_retire(32'h0000_010c, 1'b0, 1'b1, 5'd4, 32'h0000_0128);
        expect_retire(32'h0000_0110, 1'b0, 1'b1, 5'd5, 32'h0000_0123);
        expect_retire(32'h0000_0114, 1'b0, 1'b1, 5'd6, 32'hffff_fffb);
        expect_retire(32'h0000_0118, 1'b0, 1'b1, 5'd7, 32'hffff_fed8);
        expect_retire(32'h0000_011c, 1'b0, 1'b1, 5'd8, 32'h0000_00d0);
        expect_retire(32'h0000_0120, 1'b0, 1'b1, 5'd9, 32'h0000_07df);
        expect_retire(32'h0000_0124, 1'b0, 1'b1, 5'd10, 32'hffff_f820);
        expect_retire(32'h0000_0128, 1'b0, 1'b1, 5'd11, 32'habcd_e000);
        expect_retire(32'h0000_012c, 1'b0, 1'b1, 5'd12, 32'habcd_e7ff);
        end_test(name, errs);
    endtask

    task automatic test_x0();
        int errs;
        errs         = error_count;
        rand_latency = 1'b0;
        clear_mem();
        // A stored x0 would make the later sums 0x65.
        store(32'h0000_0100, enc_i(F3_ADD, 5'd0, 5'd0, 12'h055));
        store(32'h0000_0104, enc_i(F3_ADD, 5'd2, 5'd0, 12'h010));
        store(32'h0000_0108, enc_r(F7_BASE, F3_ADD, 5'd3, 5'd0, 5'd2));
        apply_reset();
        expect_retire(32'h0000_0100, 1'b0, 1'b0, 5'd0, '0);
        expect_retire(32'h0000_0104, 1'b0, 1'b1, 5'd2, 32'h0000_0010);
        expect_retire(32'h0000_0108, 1'b0, 1'b1, 5'd3, 32'h0000_0010);
        end_test("x0", errs);
    endtask

    task automatic test_branch();
        int errs;
        errs         = error_count;
        rand_latency = 1'b0;
        clear_mem();
        store(32'h0000_0100, enc_i(F3_ADD, 5'd1, 5'd0, 12'h009));
        store(32'h0000_0104, enc_i(F3_ADD, 5'd2, 5'd0, 12'h009));
        store(32'h0000_0108, enc_b(F3_BEQ, 5'd1, 5'd2, 13'd12));
        store(32'h0000_0114, enc_b(F3_BNE, 5'd1, 5'd2, 13'd16));
        store(32'h0000_0118, enc_j(5'd5, 21'd8));
        store(32'h0000_0120, enc_i(F3_ADD, 5'd6, 5'd5, 12'h001));
        apply_reset();
        expect_retire(32'h0000_0100, 1'b0, 1'b1, 5'd1, 32'h0000_0009);
        expect_retire(32'h0000_0104, 1'b0, 1'b1, 5'd2, 32'h0000_0009);
        // Taken BEQ.
        expect_retire(32'h0000_0108, 1'b0, 1'b0, 5'd0, '0);
        check_next_addr(32'h0000_0114);
        // Not-taken BNE.
        expect_retire(32'h0000_0114, 1'b0, 1'b0, 5'd0, '0);
        check_next_addr(32'h0000_0118);
        // JAL links pc+4.
        expect_retire(32'h0000_0118, 1'b0, 1'b1, 5'd5, 32'h0000_011c);
        check_next_addr(32'h0000_0120);
        expect_retire(32'h0000_0120, 1'b0, 1'b1, 5'd6, 32'h0000_011d);
        end_test("branch", errs);
    endtask

    task automatic test_illegal();
        int errs;
        errs         = error_count;
        rand_latency = 1'b0;
        clear_mem();
        store(32'h0000_0100, enc_i(F3_ADD, 5'd1, 5'd0, 12'h001));
        // Custom-0 opcode with rd = x1.
        store(32'h0000_0104, 32'h0010_008b);
        store(32'h0000_0108, enc_i(F3_ADD, 5'd2, 5'd1, 12'h002));
        apply_reset();
        expect_retire(32'h0000_0100, 1'b0, 1'b1, 5'd1, 32'h0000_0001);
        expect_retire(32'h0000_0104, 1'b1, 1'b0, 5'd0, '0);
        check_next_addr(32'h0000_0108);
        expect_retire(32'h0000_0108, 1'b0, 1'b1, 5'd2, 32'h0000_0003);
        end_test("illegal", errs);
    endtask

    // ========================================================================
    // Run control
    // ========================================================================

    initial begin
        rst = 1'b0;
        test_reset();
        run_alu_program("alu", 1'b0);
        test_x0();
        test_branch();
        run_alu_program("random latency", 1'b1);
        test_illegal();
        $display("tests %0d, checks %0d, errors %0d",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Cycle limit.
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the tests did not complete", cycle_count);
        $display("sim failed");
        $finish;
    end

endmodule

// File: list.f
common/rv_core_pkg.sv
common/dec_exec_if.sv
hdl/inst_fetch.sv
hdl/inst_decode.sv
hdl/exec_alu.sv
hdl/result_write.sv
hdl/rv_core_top.sv
dv/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - common/rv_core_pkg.sv
  - common/dec_exec_if.sv
  - hdl/inst_fetch.sv
  - hdl/inst_decode.sv
  - hdl/exec_alu.sv
  - hdl/result_write.sv
  - hdl/rv_core_top.sv
  - target: test
    files:
      - dv/tb_rv_core.sv
